//--- alu_fu.sv
/*
 * two-stage ALU, operand read then execute onto the result bus
 */
`timescale 1ns/1ps
`default_nettype none

module alu_fu (
  input  logic clock,
  input  logic reset,
  input  logic issue_valid,
  input  ooo_pkg::op_e issue_op,
  input  ooo_pkg::phys_tag_t issue_src1,
  input  ooo_pkg::phys_tag_t issue_src2,
  input  logic [7:0] issue_imm,
  input  ooo_pkg::phys_tag_t issue_dest,
  input  ooo_pkg::rob_idx_t issue_rob_idx,
  output ooo_pkg::phys_tag_t rd_tag1,
  output ooo_pkg::phys_tag_t rd_tag2,
  input  ooo_pkg::word_t rd_data1,
  input  ooo_pkg::word_t rd_data2,
  cdb_if.producer cdb
);

  // stage one holds the issue, stage two the operands
  logic               s1_valid;
  logic               s2_valid;
  ooo_pkg::op_e       s1_op;
  ooo_pkg::op_e       s2_op;
  logic [7:0]         s1_imm;
  logic [7:0]         s2_imm;
  ooo_pkg::phys_tag_t s1_dest;
  ooo_pkg::phys_tag_t s2_dest;
  ooo_pkg::rob_idx_t  s1_rob;
  ooo_pkg::rob_idx_t  s2_rob;
  ooo_pkg::phys_tag_t issue_src1_q;
  ooo_pkg::phys_tag_t issue_src2_q;
  ooo_pkg::word_t     s2_a;
  ooo_pkg::word_t     s2_b;

  assign rd_tag1 = issue_src1_q;
  assign rd_tag2 = issue_src2_q;

  always_ff @(posedge clock) begin
    s1_op <= issue_op;
    s1_imm <= issue_imm;
    s1_dest <= issue_dest;
    s1_rob <= issue_rob_idx;
    issue_src1_q <= issue_src1;
    issue_src2_q <= issue_src2;
    s2_op <= s1_op;
    s2_imm <= s1_imm;
    s2_dest <= s1_dest;
    s2_rob <= s1_rob;
    s2_a <= rd_data1;  // regfile write-through covers the current bus
    s2_b <= rd_data2;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
      s2_valid <= s1_valid;  // never stalls
    end
  end

  always_comb begin
    case (s2_op)
      ooo_pkg::OP_LI:  cdb.value = ooo_pkg::word_t'(s2_imm);  // zero-extended
      ooo_pkg::OP_ADD: cdb.value = s2_a + s2_b;
      ooo_pkg::OP_SUB: cdb.value = s2_a - s2_b;
      ooo_pkg::OP_AND: cdb.value = s2_a & s2_b;
      ooo_pkg::OP_XOR: cdb.value = s2_a ^ s2_b;
      ooo_pkg::OP_MUL: cdb.value = s2_a * s2_b;  // low 16 bits kept
      default:         cdb.value = '0;
    endcase
  end

  assign cdb.valid   = s2_valid;
  assign cdb.tag     = s2_dest;
  assign cdb.rob_idx = s2_rob;

endmodule

`default_nettype wire

//--- inst_queue.sv
/*
 * instruction queue
 * circular FIFO in front of rename, returns one credit per popped entry
 */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_consts.svh"

module inst_queue (
  input  logic           clock,
  input  logic           reset,
  input  logic           push,
  input  ooo_pkg::inst_t push_data,
  input  logic           pop,
  output ooo_pkg::inst_t head,
  output logic           not_empty,
  output logic           credit
);

  localparam int PTR_BITS = $clog2(`OOO_QUEUE_DEPTH);

  ooo_pkg::inst_t      mem [`OOO_QUEUE_DEPTH];  // payload only, no reset
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS:0]   count;

  always_ff @(posedge clock) begin
    if (push) mem[wr_ptr] <= push_data;  // source obeys credits, never overflows
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count  <= count + push - pop;
      credit <= pop;                      // one cycle after the pop
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);  // written entry shows up next cycle

endmodule

`default_nettype wire

//--- ooo_consts.svh
/*
 * core sizing constants
 * queue, ROB and RS depths, register counts, commit credits, data width
 */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define OOO_QUEUE_DEPTH    4   // also the source's starting credits
`define OOO_ROB_DEPTH      8
`define OOO_RS_DEPTH       4
`define OOO_ARCH_REGS      8
`define OOO_PHYS_REGS      16

// credits the ROB holds for the commit sink after reset
`define OOO_COMMIT_CREDITS 2

`define OOO_WORD_BITS      16

`endif

//--- ooo_core.sv
/*
 * out-of-order core top
 * queue, rename, ROB, RS, ALU and register file behind plain ports
 * with credit flow control on the instruction and commit streams
 */
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
  input  logic               clock,
  input  logic               reset,
  input  logic               inst_valid,
  input  ooo_pkg::op_e       inst_op,
  input  ooo_pkg::arch_tag_t inst_dest,
  input  ooo_pkg::arch_tag_t inst_src1,
  input  ooo_pkg::arch_tag_t inst_src2,
  input  logic [7:0]         inst_imm,
  output logic               inst_credit,    // one per freed queue slot
  input  logic               commit_credit,  // one per consumed commit
  output logic               commit_valid,
  output ooo_pkg::arch_tag_t commit_arch_idx,
  output ooo_pkg::word_t     commit_value
);

  cdb_if      u_cdb ();
  dispatch_if u_disp ();

  ooo_pkg::inst_t     push_data;
  ooo_pkg::inst_t     q_head;
  logic               q_not_empty;
  logic               q_pop;
  logic               retire_valid;
  ooo_pkg::phys_tag_t retire_old_tag;

  logic               issue_valid;
  ooo_pkg::op_e       issue_op;
  ooo_pkg::phys_tag_t issue_src1;
  ooo_pkg::phys_tag_t issue_src2;
  logic [7:0]         issue_imm;
  ooo_pkg::phys_tag_t issue_dest;
  ooo_pkg::rob_idx_t  issue_rob_idx;
  ooo_pkg::phys_tag_t rd_tag1;
  ooo_pkg::phys_tag_t rd_tag2;
  ooo_pkg::word_t     rd_data1;
  ooo_pkg::word_t     rd_data2;

  // pack the port fields into one queue entry
  always_comb begin
    push_data.op   = inst_op;
    push_data.dest = inst_dest;
    push_data.src1 = inst_src1;
    push_data.src2 = inst_src2;
    push_data.imm  = inst_imm;
  end

  ////////////////////
  // front end
  ////////////////////

  inst_queue u_queue (
    .clock(clock), .reset(reset),
    .push(inst_valid), .push_data(push_data),
    .pop(q_pop), .head(q_head), .not_empty(q_not_empty),
    .credit(inst_credit)
  );

  rename_unit u_rename (
    .clock(clock), .reset(reset),
    .head(q_head), .not_empty(q_not_empty), .pop(q_pop),
    .disp(u_disp.source), .cdb(u_cdb.consumer),
    .retire_valid(retire_valid), .retire_old_tag(retire_old_tag)
  );

  rob u_rob (
    .clock(clock), .reset(reset),
    .disp(u_disp.sink), .cdb(u_cdb.consumer),
    .commit_credit(commit_credit), .commit_valid(commit_valid),
    .commit_arch_idx(commit_arch_idx), .commit_value(commit_value),
    .retire_valid(retire_valid), .retire_old_tag(retire_old_tag)
  );

  ////////////////////
  // back end
  ////////////////////

  rs u_rs (
    .clock(clock), .reset(reset),
    .disp(u_disp.sink), .cdb(u_cdb.consumer),
    .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_src1(issue_src1), .issue_src2(issue_src2),
    .issue_imm(issue_imm), .issue_dest(issue_dest),
    .issue_rob_idx(issue_rob_idx)
  );

  alu_fu u_alu (
    .clock(clock), .reset(reset),
    .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_src1(issue_src1), .issue_src2(issue_src2),
    .issue_imm(issue_imm), .issue_dest(issue_dest),
    .issue_rob_idx(issue_rob_idx),
    .rd_tag1(rd_tag1), .rd_tag2(rd_tag2),
    .rd_data1(rd_data1), .rd_data2(rd_data2),
    .cdb(u_cdb.producer)
  );

  phys_regfile u_prf (
    .clock(clock), .reset(reset), .cdb(u_cdb.consumer),
    .rd_tag1(rd_tag1), .rd_tag2(rd_tag2),
    .rd_data1(rd_data1), .rd_data2(rd_data2)
  );

endmodule

`default_nettype wire

//--- ooo_ifs.sv
/*
 * result bus and dispatch interfaces of the core
 */
`timescale 1ns/1ps
`default_nettype none

// one result per cycle, no handshake
interface cdb_if;
  logic                 valid;
  ooo_pkg::phys_tag_t   tag;
  ooo_pkg::word_t       value;
  ooo_pkg::rob_idx_t    rob_idx;

  modport producer (output valid, tag, value, rob_idx);
  modport consumer (input valid, tag, value, rob_idx);
endinterface

// rename decides, ROB and RS just take the entry
interface dispatch_if;
  logic                 valid;
  ooo_pkg::dispatch_t   payload;
  logic                 rob_full;  // from ROB
  logic                 rs_full;   // from RS
  ooo_pkg::rob_idx_t    rob_idx;   // ROB tail

  modport source (output valid, payload, input rob_full, rs_full, rob_idx);
  modport sink   (input valid, payload, output rob_full, rs_full, rob_idx);
endinterface

`default_nettype wire

//--- ooo_pkg.sv
/*
 * shared types of the out-of-order core
 * opcodes, tags, data word, instruction, dispatch and commit records
 */
`default_nettype none
`include "ooo_consts.svh"

package ooo_pkg;

  typedef enum logic [2:0] {
    OP_LI,   // dest = zero-extended imm
    OP_ADD,
    OP_SUB,  // src1 - src2, wraps
    OP_AND,
    OP_XOR,
    OP_MUL   // low half of the product
  } op_e;

  typedef logic [`OOO_WORD_BITS-1:0]           word_t;
  typedef logic [$clog2(`OOO_ARCH_REGS)-1:0]   arch_tag_t;
  typedef logic [$clog2(`OOO_PHYS_REGS)-1:0]   phys_tag_t;
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]   rob_idx_t;

  // instruction as it arrives at the core
  typedef struct packed {
    op_e       op;
    arch_tag_t dest;
    arch_tag_t src1;
    arch_tag_t src2;
    logic [7:0] imm;
  } inst_t;

  // renamed instruction, written into ROB and RS
  typedef struct packed {
    op_e       op;
    phys_tag_t dest;      // newly allocated tag
    phys_tag_t src1;
    logic      src1_rdy;
    phys_tag_t src2;
    logic      src2_rdy;
    logic [7:0] imm;
    arch_tag_t arch_dest;
    phys_tag_t old_dest;  // freed at retirement
    rob_idx_t  rob_idx;
  } dispatch_t;

  // what leaves the core at commit
  typedef struct packed {
    arch_tag_t arch_idx;
    word_t     value;
  } commit_t;

endpackage

`default_nettype wire

//--- phys_regfile.sv
/*
 * physical register file, two reads, one bus write, write-through
 */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_consts.svh"

module phys_regfile (
  input  logic               clock,
  input  logic               reset,
  cdb_if.consumer            cdb,
  input  ooo_pkg::phys_tag_t rd_tag1,
  input  ooo_pkg::phys_tag_t rd_tag2,
  output ooo_pkg::word_t     rd_data1,
  output ooo_pkg::word_t     rd_data2
);

  ooo_pkg::word_t regs [`OOO_PHYS_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `OOO_PHYS_REGS; i++) regs[i] <= '0;  // arch regs start at zero
    end else if (cdb.valid) begin
      regs[cdb.tag] <= cdb.value;
    end
  end

  // same-cycle write shows on the read
  assign rd_data1 = (cdb.valid && cdb.tag == rd_tag1) ? cdb.value : regs[rd_tag1];
  assign rd_data2 = (cdb.valid && cdb.tag == rd_tag2) ? cdb.value : regs[rd_tag2];

endmodule

`default_nettype wire

//--- rename_unit.sv
/*
 * rename stage
 * map table, free list and physical ready bits, decides dispatch
 */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_consts.svh"

module rename_unit (
  input  logic               clock,
  input  logic               reset,
  input  ooo_pkg::inst_t     head,
  input  logic               not_empty,
  output logic               pop,
  dispatch_if.source         disp,
  cdb_if.consumer            cdb,
  input  logic               retire_valid,
  input  ooo_pkg::phys_tag_t retire_old_tag
);

  localparam int FL_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;  // never more free than this
  localparam int FL_BITS  = $clog2(FL_DEPTH);

  ooo_pkg::phys_tag_t  map_tbl [`OOO_ARCH_REGS];
  ooo_pkg::phys_tag_t  free_list [FL_DEPTH];
  logic [FL_BITS-1:0]  fl_head;
  logic [FL_BITS-1:0]  fl_tail;
  logic [FL_BITS:0]    fl_count;
  logic [`OOO_PHYS_REGS-1:0] ready;

  ooo_pkg::phys_tag_t  src1_tag;
  ooo_pkg::phys_tag_t  src2_tag;
  ooo_pkg::phys_tag_t  new_tag;
  logic                no_srcs;

  ////////////////////
  // lookup
  ////////////////////

  assign src1_tag = map_tbl[head.src1];
  assign src2_tag = map_tbl[head.src2];
  assign new_tag  = free_list[fl_head];
  assign no_srcs  = (head.op == ooo_pkg::OP_LI);  // LI waits on nothing

  // all four conditions, nobody else checks them
  assign disp.valid = not_empty && (fl_count != '0) && !disp.rob_full && !disp.rs_full;
  assign pop        = disp.valid;

  always_comb begin
    disp.payload           = '0;
    disp.payload.op        = head.op;
    disp.payload.dest      = new_tag;
    disp.payload.src1      = src1_tag;
    disp.payload.src2      = src2_tag;
    // ready bit, or the result on the bus this cycle
    disp.payload.src1_rdy  = no_srcs || ready[src1_tag] || (cdb.valid && cdb.tag == src1_tag);
    disp.payload.src2_rdy  = no_srcs || ready[src2_tag] || (cdb.valid && cdb.tag == src2_tag);
    disp.payload.imm       = head.imm;
    disp.payload.arch_dest = head.dest;
    disp.payload.old_dest  = map_tbl[head.dest];  // read before this dispatch updates it
    disp.payload.rob_idx   = disp.rob_idx;
  end

  ////////////////////
  // state
  ////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
        map_tbl[i] <= ooo_pkg::phys_tag_t'(i);  // identity map, regs 0..7
      end
      for (int i = 0; i < FL_DEPTH; i++) begin
        free_list[i] <= ooo_pkg::phys_tag_t'(`OOO_ARCH_REGS + i);  // tags 8..15
      end
      fl_head  <= '0;
      fl_tail  <= '0;  // full list, tail wrapped onto head
      fl_count <= (FL_BITS+1)'(FL_DEPTH);
      ready    <= '1;
    end else begin
      if (disp.valid) begin
        map_tbl[head.dest] <= new_tag;
        fl_head            <= fl_head + 1'b1;
      end
      if (retire_valid) begin  // old mapping is dead once its successor commits
        free_list[fl_tail] <= retire_old_tag;
        fl_tail            <= fl_tail + 1'b1;
      end
      fl_count <= fl_count + retire_valid - disp.valid;
      // allocated tag is free, so it is never on the bus at the same time
      if (cdb.valid)  ready[cdb.tag] <= 1'b1;
      if (disp.valid) ready[new_tag] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rob.sv
/*
 * reorder buffer
 * allocates at dispatch, marks results from the bus, retires in order
 * while the commit sink has credits left
 */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_consts.svh"

module rob (
  input  logic               clock,
  input  logic               reset,
  dispatch_if.sink           disp,
  cdb_if.consumer            cdb,
  input  logic               commit_credit,
  output logic               commit_valid,
  output ooo_pkg::arch_tag_t commit_arch_idx,
  output ooo_pkg::word_t     commit_value,
  output logic               retire_valid,
  output ooo_pkg::phys_tag_t retire_old_tag
);

  localparam int CNT_BITS  = $clog2(`OOO_ROB_DEPTH) + 1;
  localparam int CRED_BITS = $clog2(`OOO_COMMIT_CREDITS + 1);

  ooo_pkg::commit_t   entry   [`OOO_ROB_DEPTH];  // arch dest and result
  ooo_pkg::phys_tag_t old_tag [`OOO_ROB_DEPTH];
  logic [`OOO_ROB_DEPTH-1:0] done;

  ooo_pkg::rob_idx_t  head_ptr;
  ooo_pkg::rob_idx_t  tail_ptr;
  logic [CNT_BITS-1:0]  count;
  logic [CRED_BITS-1:0] credits;
  logic               retire;

  assign disp.rob_full = (count == CNT_BITS'(`OOO_ROB_DEPTH));
  assign disp.rob_idx  = tail_ptr;

  // done is registered, so head goes the cycle after its result
  assign retire = (count != '0) && done[head_ptr] && (credits != '0);

  always_ff @(posedge clock) begin
    if (disp.valid) begin
      entry[tail_ptr].arch_idx <= disp.payload.arch_dest;
      old_tag[tail_ptr]        <= disp.payload.old_dest;
    end
    if (cdb.valid) entry[cdb.rob_idx].value <= cdb.value;  // result lands by ROB index
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
      done     <= '0;
      credits  <= CRED_BITS'(`OOO_COMMIT_CREDITS);
    end else begin
      if (disp.valid) begin
        done[tail_ptr] <= 1'b0;
        tail_ptr       <= tail_ptr + 1'b1;
      end
      if (cdb.valid) done[cdb.rob_idx] <= 1'b1;  // never the slot being allocated
      if (retire) head_ptr <= head_ptr + 1'b1;
      count   <= count + disp.valid - retire;
      credits <= credits + commit_credit - retire;  // sink returns what it consumed
    end
  end

  // commit and retire are the same event
  assign commit_valid    = retire;
  assign commit_arch_idx = entry[head_ptr].arch_idx;
  assign commit_value    = entry[head_ptr].value;
  assign retire_valid    = retire;
  assign retire_old_tag  = old_tag[head_ptr];

endmodule

`default_nettype wire

//--- rs.sv
/*
 * reservation station
 * age-ordered entries, bus wakeup, issues the oldest ready entry
 */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_consts.svh"

module rs (
  input  logic               clock,
  input  logic               reset,
  dispatch_if.sink           disp,
  cdb_if.consumer            cdb,
  output logic               issue_valid,
  output ooo_pkg::op_e       issue_op,
  output ooo_pkg::phys_tag_t issue_src1,
  output ooo_pkg::phys_tag_t issue_src2,
  output logic [7:0]         issue_imm,
  output ooo_pkg::phys_tag_t issue_dest,
  output ooo_pkg::rob_idx_t  issue_rob_idx
);

  localparam int D        = `OOO_RS_DEPTH;
  localparam int IDX_BITS = $clog2(D);

  // slot 0 is the oldest, valid slots stay packed at the bottom
  ooo_pkg::dispatch_t ent   [D];
  ooo_pkg::dispatch_t woke  [D];
  ooo_pkg::dispatch_t nxt   [D];
  logic [D-1:0]       valid;
  logic [D-1:0]       nxt_valid;
  logic [IDX_BITS:0]  count;
  logic [IDX_BITS-1:0] sel;
  logic [IDX_BITS:0]  fill;

  assign disp.rs_full = (count == (IDX_BITS+1)'(D));

  // oldest with both operands ready
  always_comb begin
    issue_valid = 1'b0;
    sel         = '0;
    for (int i = D - 1; i >= 0; i--) begin
      if (valid[i] && ent[i].src1_rdy && ent[i].src2_rdy) begin
        issue_valid = 1'b1;
        sel         = IDX_BITS'(i);
      end
    end
  end

  assign issue_op      = ent[sel].op;
  assign issue_src1    = ent[sel].src1;
  assign issue_src2    = ent[sel].src2;
  assign issue_imm     = ent[sel].imm;
  assign issue_dest    = ent[sel].dest;
  assign issue_rob_idx = ent[sel].rob_idx;

  assign fill = count - issue_valid;  // first free slot after the shift

  always_comb begin
    woke = ent;
    for (int i = 0; i < D; i++) begin  // wakeup, seen by select next cycle
      if (cdb.valid && cdb.tag == ent[i].src1) woke[i].src1_rdy = 1'b1;
      if (cdb.valid && cdb.tag == ent[i].src2) woke[i].src2_rdy = 1'b1;
    end
    nxt       = woke;
    nxt_valid = valid;
    if (issue_valid) begin  // close the gap left by the issued entry
      for (int i = 0; i < D - 1; i++) begin
        if (i >= int'(sel)) begin
          nxt[i]       = woke[i+1];
          nxt_valid[i] = valid[i+1];
        end
      end
      nxt_valid[D-1] = 1'b0;
    end
    if (disp.valid) begin
      nxt[fill[IDX_BITS-1:0]]       = disp.payload;
      nxt_valid[fill[IDX_BITS-1:0]] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    ent <= nxt;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      count <= '0;
    end else begin
      valid <= nxt_valid;
      count <= count + disp.valid - issue_valid;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
ooo_pkg.sv
ooo_ifs.sv
inst_queue.sv
rename_unit.sv
rob.sv
rs.sv
alu_fu.sv
phys_regfile.sv
ooo_core.sv
tb_ooo_core.sv

//--- tb_ooo_core.sv
/*
 * testbench for the out-of-order core
 * table-driven programs, reference model, credit source and sink,
 * commit monitor, watchdog and report
 */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_consts.svh"

module tb_ooo_core;

  localparam int STALL_CYCLES = 30;  // source idle this long means the core is full

  // table row, repeated reps times back to back
  typedef struct packed {
    logic [3:0]         test;
    ooo_pkg::op_e       op;
    ooo_pkg::arch_tag_t dest;
    ooo_pkg::arch_tag_t src1;
    ooo_pkg::arch_tag_t src2;
    logic [7:0]         imm;
    logic               hold;  // sink withholds commit credits during this test
    logic [7:0]         reps;
  } row_t;

  logic               clock;
  logic               reset;
  logic               inst_valid;
  ooo_pkg::op_e       inst_op;
  ooo_pkg::arch_tag_t inst_dest;
  ooo_pkg::arch_tag_t inst_src1;
  ooo_pkg::arch_tag_t inst_src2;
  logic [7:0]         inst_imm;
  logic               inst_credit;
  logic               commit_credit;
  logic               commit_valid;
  ooo_pkg::arch_tag_t commit_arch_idx;
  ooo_pkg::word_t     commit_value;

  row_t               rows [$];
  ooo_pkg::word_t     ref_regs [`OOO_ARCH_REGS];  // architectural state from zero
  ooo_pkg::arch_tag_t exp_idx [$];
  ooo_pkg::word_t     exp_val [$];

  integer seed = 32'hbe3b_02bf;
  int     src_credits = `OOO_QUEUE_DEPTH;
  int     owed;          // commits not yet paid back to the core
  int     gap;           // sink delay before the next credit
  logic   give_credit;
  logic   withhold;
  int     hold_commits;
  int     sent, commits, credits_seen;
  int     errors, checks, n_tests;
  int     watch_cycles;
  int     cycle;         // rising edges so far
  int     first_cycle;   // edge count when the first instruction was driven

  ooo_core u_dut (
    .clock(clock), .reset(reset),
    .inst_valid(inst_valid), .inst_op(inst_op), .inst_dest(inst_dest),
    .inst_src1(inst_src1), .inst_src2(inst_src2), .inst_imm(inst_imm),
    .inst_credit(inst_credit), .commit_credit(commit_credit),
    .commit_valid(commit_valid), .commit_arch_idx(commit_arch_idx),
    .commit_value(commit_value)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle++;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic ooo_pkg::word_t ref_exec(input ooo_pkg::op_e op, input ooo_pkg::word_t a,
                                              input ooo_pkg::word_t b, input logic [7:0] imm);
    logic [31:0] product;
    product = a * b;  // full product before truncation
    case (op)
      ooo_pkg::OP_LI:  return {8'h00, imm};
      ooo_pkg::OP_ADD: return a + b;
      ooo_pkg::OP_SUB: return a - b;  // wraps
      ooo_pkg::OP_AND: return a & b;
      ooo_pkg::OP_XOR: return a ^ b;
      ooo_pkg::OP_MUL: return product[15:0];
      default:         return 16'h0000;
    endcase
  endfunction

  task automatic add_row(input int test, input ooo_pkg::op_e op, input int dest, input int src1,
                         input int src2, input int imm, input int hold, input int reps);
    row_t r;
    r.test = 4'(test);
    r.op   = op;
    r.dest = ooo_pkg::arch_tag_t'(dest);
    r.src1 = ooo_pkg::arch_tag_t'(src1);
    r.src2 = ooo_pkg::arch_tag_t'(src2);
    r.imm  = 8'(imm);
    r.hold = 1'(hold);
    r.reps = 8'(reps);
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(1, ooo_pkg::OP_LI,  1, 0, 0, 'h05, 0, 1);   // fills the queue on start credits
    add_row(1, ooo_pkg::OP_LI,  2, 0, 0, 'h0a, 0, 1);
    add_row(1, ooo_pkg::OP_ADD, 3, 1, 2, 0,    0, 1);
    add_row(1, ooo_pkg::OP_XOR, 4, 3, 1, 0,    0, 1);
    add_row(2, ooo_pkg::OP_LI,  1, 0, 0, 'h03, 0, 1);   // dependent chain
    add_row(2, ooo_pkg::OP_ADD, 2, 1, 1, 0,    0, 1);
    add_row(2, ooo_pkg::OP_MUL, 3, 2, 1, 0,    0, 1);
    add_row(2, ooo_pkg::OP_SUB, 4, 3, 2, 0,    0, 1);
    add_row(3, ooo_pkg::OP_LI,  5, 0, 0, 'hc8, 0, 1);   // slow MUL chain
    add_row(3, ooo_pkg::OP_MUL, 6, 5, 5, 0,    0, 1);
    add_row(3, ooo_pkg::OP_MUL, 6, 6, 5, 0,    0, 1);
    add_row(3, ooo_pkg::OP_LI,  7, 0, 0, 'h09, 0, 1);   // independent of the MUL chain
    add_row(3, ooo_pkg::OP_XOR, 0, 7, 1, 0,    0, 1);
    add_row(3, ooo_pkg::OP_AND, 2, 4, 7, 0,    0, 1);
    add_row(3, ooo_pkg::OP_SUB, 3, 6, 7, 0,    0, 1);
    add_row(3, ooo_pkg::OP_ADD, 0, 0, 2, 0,    0, 1);
    add_row(4, ooo_pkg::OP_LI,  1, 0, 0, 'h01, 0, 1);   // many writes so tags must recycle
    add_row(4, ooo_pkg::OP_LI,  2, 0, 0, 'h03, 0, 1);
    add_row(4, ooo_pkg::OP_ADD, 1, 1, 2, 0,    0, 10);
    add_row(4, ooo_pkg::OP_SUB, 2, 1, 2, 0,    0, 8);
    add_row(5, ooo_pkg::OP_LI,  4, 0, 0, 'h07, 1, 1);   // back-pressure from the sink
    add_row(5, ooo_pkg::OP_ADD, 3, 3, 4, 0,    1, 8);
    add_row(5, ooo_pkg::OP_XOR, 4, 4, 3, 0,    1, 7);
  endtask

  ////////////////////
  // source side
  ////////////////////

  task automatic release_hold();
    checks++;
    if (hold_commits != `OOO_COMMIT_CREDITS) begin
      $display("FAIL at %0t: %0d commits while credits were withheld, expected %0d",
               $time, hold_commits, `OOO_COMMIT_CREDITS);
      errors++;
    end
    withhold = 1'b0;
  endtask

  // sends one instruction once a credit is held
  task automatic send_inst(input row_t r);
    int             waited;
    ooo_pkg::word_t value;
    waited = 0;
    @(posedge clock);
    #1;
    while (src_credits == 0) begin
      inst_valid = 1'b0;
      waited++;
      if (withhold && waited == STALL_CYCLES) release_hold();
      @(posedge clock);
      #1;
    end
    inst_valid = 1'b1;
    inst_op    = r.op;
    inst_dest  = r.dest;
    inst_src1  = r.src1;
    inst_src2  = r.src2;
    inst_imm   = r.imm;
    if (sent == 0) first_cycle = cycle;
    src_credits--;
    sent++;
    value = ref_exec(r.op, ref_regs[r.src1], ref_regs[r.src2], r.imm);
    ref_regs[r.dest] = value;
    exp_idx.push_back(r.dest);
    exp_val.push_back(value);
  endtask

  task automatic wait_drain();
    while (exp_val.size() != 0 || owed != 0) @(posedge clock);
    repeat (2) @(posedge clock);
    #1;
  endtask

  ////////////////////
  // sink and monitor
  ////////////////////

  // decided on the edge and driven 1 ns later
  always @(posedge clock) begin
    give_credit = (owed > 0) && !withhold && (gap == 0);
    if ((owed > 0) && !withhold && (gap != 0)) gap = gap - 1;
    #1;
    commit_credit = give_credit;
    if (give_credit) begin
      owed = owed - 1;
      gap  = $random(seed) & 3;  // 0 to 3 idle cycles
    end
  end

  always @(negedge clock) begin
    if (!reset) begin
      if (inst_credit) begin
        credits_seen++;
        src_credits++;
        // push, visible and popped next cycle, credit one cycle after the pop
        if (credits_seen == 1 && (sent == 0 || cycle != first_cycle + 2)) begin
          $display("first instruction credit came %0d cycles after the first send at %0t",
                   cycle - first_cycle, $time);
          errors++;
        end
        if (src_credits > `OOO_QUEUE_DEPTH) begin
          $display("core returned more instruction credits than queue slots at %0t", $time);
          errors++;
        end
      end
      if (commit_valid) begin
        commits++;
        checks++;
        owed++;
        if (withhold) hold_commits++;
        if (owed > `OOO_COMMIT_CREDITS) begin
          $display("core committed without a commit credit at %0t", $time);
          errors++;
        end
        if (exp_val.size() == 0) begin
          $display("core committed with no instruction outstanding at %0t", $time);
          errors++;
        end else if (commit_arch_idx !== exp_idx[0] || commit_value !== exp_val[0]) begin
          $display("FAIL at %0t: commit r%0d = %h, expected r%0d = %h", $time,
                   commit_arch_idx, commit_value, exp_idx[0], exp_val[0]);
          errors++;
        end
        if (exp_val.size() != 0) begin
          void'(exp_idx.pop_front());
          void'(exp_val.pop_front());
        end
      end
    end
  end

  // 40 cycles per instruction plus slack
  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", watch_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int   i;
    int   k;
    int   total;
    int   test_id;
    int   errs_before;
    int   sent_before;
    logic hold_used;
    reset         = 1'b1;
    inst_valid    = 1'b0;
    inst_op       = ooo_pkg::OP_LI;
    inst_dest     = '0;
    inst_src1     = '0;
    inst_src2     = '0;
    inst_imm      = '0;
    commit_credit = 1'b0;
    withhold      = 1'b0;
    for (i = 0; i < `OOO_ARCH_REGS; i++) ref_regs[i] = '0;
    build_table();
    total = 0;
    foreach (rows[j]) total += rows[j].reps;
    watch_cycles = 40 * total + 200;

    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;

    // idle core stays quiet
    repeat (5) begin
      @(negedge clock);
      checks++;
      if (inst_credit !== 1'b0 || commit_valid !== 1'b0) begin
        $display("credit or commit seen before any instruction at %0t", $time);
        errors++;
      end
    end

    i = 0;
    while (i < rows.size()) begin
      test_id     = rows[i].test;
      errs_before = errors;
      sent_before = sent;
      hold_used   = 1'b0;
      while (i < rows.size() && rows[i].test == test_id) begin
        if (rows[i].hold && !hold_used) begin
          hold_used    = 1'b1;
          hold_commits = 0;
          withhold     = 1'b1;
        end
        for (k = 0; k < rows[i].reps; k++) send_inst(rows[i]);
        i++;
      end
      @(posedge clock);
      #1;
      inst_valid = 1'b0;
      if (withhold) begin  // core should have filled up and stopped the source
        $display("source never ran out of credits while commits were held in test %0d",
                 test_id);
        errors++;
        withhold = 1'b0;
      end
      wait_drain();
      n_tests++;
      $display("test %0d done: %0d instructions, %0d errors", test_id,
               sent - sent_before, errors - errs_before);
    end

    repeat (10) @(posedge clock);
    checks += 2;
    if (commits != sent) begin
      $display("%0d instructions sent but %0d commits seen", sent, commits);
      errors++;
    end
    if (credits_seen != sent) begin
      $display("%0d instructions sent but %0d instruction credits returned", sent, credits_seen);
      errors++;
    end
    $display("%0d tests, %0d instructions, %0d checks, %0d errors", n_tests, sent, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
